/* hdl/mem_stage_defines.svh */
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// ******************************
// datapath and storage sizes
// ******************************

// data word and address width
`define MEM_DATA_W 32

// fully associative, so keep it small
`define MEM_TLB_ENTRIES 4

// indexed by physical address bits 9 to 2
`define MEM_WORDS 256

// 4 KB pages
`define MEM_PAGE_BITS 12

`endif

/* hdl/mem_stage_pkg.sv */
`default_nettype none

`include "mem_stage_defines.svh"

package mem_stage_pkg;

    // operand source, regs first so the low bits pick the register
    typedef enum logic [2:0] {
        OPSEL_REG0 = 3'd0,
        OPSEL_REG1 = 3'd1,
        OPSEL_REG2 = 3'd2,
        OPSEL_REG3 = 3'd3,
        OPSEL_MEM1 = 3'd4,
        OPSEL_MEM2 = 3'd5,
        OPSEL_IMM  = 3'd6,
        OPSEL_EIP  = 3'd7
    } opsel_e;

    typedef struct packed {
        logic                   valid;
        logic                   is_rep;
        logic                   df;
        logic [`MEM_DATA_W-1:0] addr1;
        logic [`MEM_DATA_W-1:0] addr2;
        logic                   rw1;
        logic                   rw2;
        logic [15:0]            rep_count;
        opsel_e [3:0]           sel;
        logic [`MEM_DATA_W-1:0] imm;
        logic [`MEM_DATA_W-1:0] eip;
        logic [6:0]             tag;
    } mem_uop_t;

    typedef struct packed {
        logic                                     valid;
        logic [$clog2(`MEM_TLB_ENTRIES)-1:0]      index;
        logic [`MEM_DATA_W-`MEM_PAGE_BITS-1:0]    vpn;
        logic [`MEM_DATA_W-`MEM_PAGE_BITS-1:0]    pfn;
        logic                                     present;
        logic                                     writable;
    } tlb_wr_t;

    typedef struct packed {
        logic                   valid;
        logic [`MEM_DATA_W-1:0] phys_addr;
        logic [`MEM_DATA_W-1:0] data;
    } wb_req_t;

    typedef struct packed {
        logic                        valid;
        logic [6:0]                  tag;
        logic [3:0][`MEM_DATA_W-1:0] ops;
        logic [`MEM_DATA_W-1:0]      phys1;
        logic [`MEM_DATA_W-1:0]      phys2;
        logic                        tlb_miss;
        logic                        prot_exc;
    } mem_out_t;

endpackage

`default_nettype wire

/* hdl/rep_addr_gen.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_stage_defines.svh"

module rep_addr_gen
    import mem_stage_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire mem_uop_t                uop_i,
    output logic                         issue_o,
    output logic [`MEM_DATA_W-1:0]       addr1_o,
    output logic [`MEM_DATA_W-1:0]       addr2_o,
    output logic                         stall_o
);

    localparam logic [`MEM_DATA_W-1:0] WORD_STEP = 4;

    logic                   active_q;
    logic [15:0]            count_q;
    logic [`MEM_DATA_W-1:0] addr1_q;
    logic [`MEM_DATA_W-1:0] addr2_q;
    logic                   df_q;

    logic [15:0]            cur_count;
    logic                   cur_df;
    logic [`MEM_DATA_W-1:0] step;

    // idle takes the incoming uop, active replays the running state
    always_comb begin
        if (active_q) begin
            cur_count = count_q;
            cur_df    = df_q;
            addr1_o   = addr1_q;
            addr2_o   = addr2_q;
            issue_o   = 1'b1;
        end else begin
            cur_count = uop_i.is_rep ? uop_i.rep_count : 16'd1;
            cur_df    = uop_i.df;
            addr1_o   = uop_i.addr1;
            addr2_o   = uop_i.addr2;
            // rep with zero count is dropped
            issue_o   = uop_i.valid && (cur_count != 16'd0);
        end
    end

    // df set walks down
    assign step = cur_df ? -WORD_STEP : WORD_STEP;

    // count_q is the number of issues still owed after this one
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
            count_q  <= '0;
        end else if (issue_o) begin
            active_q <= (cur_count > 16'd1);
            count_q  <= cur_count - 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_o) begin
            addr1_q <= addr1_o + step;
            addr2_q <= addr2_o + step;
            df_q    <= cur_df;
        end
    end

    // more repeats pending, hold upstream
    assign stall_o = active_q;

endmodule

`default_nettype wire

/* hdl/dtlb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_stage_defines.svh"

module dtlb
    import mem_stage_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire tlb_wr_t                 tlb_wr_i,
    input  wire [`MEM_DATA_W-1:0]        vaddr1_i,
    input  wire [`MEM_DATA_W-1:0]        vaddr2_i,
    input  wire                          rw1_i,
    input  wire                          rw2_i,
    output logic [`MEM_DATA_W-1:0]       paddr1_o,
    output logic [`MEM_DATA_W-1:0]       paddr2_o,
    output logic                         miss1_o,
    output logic                         miss2_o,
    output logic                         prot1_o,
    output logic                         prot2_o
);

    localparam int N     = `MEM_TLB_ENTRIES;
    localparam int PB    = `MEM_PAGE_BITS;
    localparam int VPN_W = `MEM_DATA_W - `MEM_PAGE_BITS;

    logic [N-1:0]               present_q;
    logic [N-1:0]               writable_q;
    logic [VPN_W-1:0]           vpn_q [N];
    logic [VPN_W-1:0]           pfn_q [N];

    logic [1:0][`MEM_DATA_W-1:0] vaddr;
    logic [1:0]                  rw;
    logic [1:0]                  hit;
    logic [1:0]                  wr_ok;
    logic [1:0][VPN_W-1:0]       pfn;

    // ******************************
    // entry storage
    // ******************************

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            present_q <= '0;
        end else if (tlb_wr_i.valid) begin
            present_q[tlb_wr_i.index] <= tlb_wr_i.present;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_wr_i.valid) begin
            writable_q[tlb_wr_i.index] <= tlb_wr_i.writable;
            vpn_q[tlb_wr_i.index]      <= tlb_wr_i.vpn;
            pfn_q[tlb_wr_i.index]      <= tlb_wr_i.pfn;
        end
    end

    // ******************************
    // lookup, both ports
    // ******************************

    assign vaddr = {vaddr2_i, vaddr1_i};
    assign rw    = {rw2_i, rw1_i};

    // duplicate mappings resolve to the highest index
    always_comb begin
        hit   = '0;
        wr_ok = '0;
        pfn   = '0;
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < N; i++) begin
                if (present_q[i] && (vpn_q[i] == vaddr[p][`MEM_DATA_W-1:PB])) begin
                    hit[p]   = 1'b1;
                    wr_ok[p] = writable_q[i];
                    pfn[p]   = pfn_q[i];
                end
            end
        end
    end

    assign paddr1_o = {pfn[0], vaddr1_i[PB-1:0]};
    assign paddr2_o = {pfn[1], vaddr2_i[PB-1:0]};

    assign miss1_o = ~hit[0];
    assign miss2_o = ~hit[1];

    // no entry, no protection fault
    assign prot1_o = hit[0] & rw[0] & ~wr_ok[0];
    assign prot2_o = hit[1] & rw[1] & ~wr_ok[1];

endmodule

`default_nettype wire

/* hdl/dcache_mem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_stage_defines.svh"

module dcache_mem
    import mem_stage_pkg::*;
(
    input  wire                          clk,
    input  wire                          rd_en_i,
    input  wire [`MEM_DATA_W-1:0]        raddr1_i,
    input  wire [`MEM_DATA_W-1:0]        raddr2_i,
    input  wire wb_req_t                 wb_i,
    output logic [`MEM_DATA_W-1:0]       rdata1_o,
    output logic [`MEM_DATA_W-1:0]       rdata2_o
);

    localparam int AW = $clog2(`MEM_WORDS);

    logic [`MEM_DATA_W-1:0] mem_q [`MEM_WORDS];

    logic [AW-1:0] ridx1;
    logic [AW-1:0] ridx2;
    logic [AW-1:0] widx;

    // word index, byte offset dropped
    assign ridx1 = raddr1_i[AW+1:2];
    assign ridx2 = raddr2_i[AW+1:2];
    assign widx  = wb_i.phys_addr[AW+1:2];

    // writeback port
    always_ff @(posedge clk) begin
        if (wb_i.valid) begin
            mem_q[widx] <= wb_i.data;
        end
    end

    // same-edge write is not seen by these reads
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rdata1_o <= mem_q[ridx1];
            rdata2_o <= mem_q[ridx2];
        end
    end

endmodule

`default_nettype wire

/* hdl/operand_select.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_stage_defines.svh"

module operand_select
    import mem_stage_pkg::*;
(
    input  wire opsel_e [3:0]                  sel_i,
    input  wire [3:0][`MEM_DATA_W-1:0]         regs_i,
    input  wire [`MEM_DATA_W-1:0]              mem1_i,
    input  wire [`MEM_DATA_W-1:0]              mem2_i,
    input  wire [`MEM_DATA_W-1:0]              imm_i,
    input  wire [`MEM_DATA_W-1:0]              eip_i,
    output logic [3:0][`MEM_DATA_W-1:0]        ops_o
);

    // ******************************
    // one mux per operand slot
    // ******************************

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            case (sel_i[i])
                OPSEL_MEM1: begin
                    ops_o[i] = mem1_i;
                end
                OPSEL_MEM2: begin
                    ops_o[i] = mem2_i;
                end
                OPSEL_IMM: begin
                    ops_o[i] = imm_i;
                end
                OPSEL_EIP: begin
                    ops_o[i] = eip_i;
                end
                // reg0..reg3, low two bits are the register number
                default: begin
                    ops_o[i] = regs_i[sel_i[i][1:0]];
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_stage_defines.svh"

module mem_stage
    import mem_stage_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire mem_uop_t                uop_i,
    input  wire [3:0][`MEM_DATA_W-1:0]   regs_i,
    input  wire tlb_wr_t                 tlb_wr_i,
    input  wire wb_req_t                 wb_i,
    output mem_out_t                     out_o,
    output logic                         stall_o
);

    mem_uop_t                    hold_q;
    logic [3:0][`MEM_DATA_W-1:0] regs_hold_q;
    mem_uop_t                    cur_uop;
    logic [3:0][`MEM_DATA_W-1:0] cur_regs;

    logic                        issue;
    logic [`MEM_DATA_W-1:0]      addr1;
    logic [`MEM_DATA_W-1:0]      addr2;
    logic [`MEM_DATA_W-1:0]      paddr1;
    logic [`MEM_DATA_W-1:0]      paddr2;
    logic                        miss1;
    logic                        miss2;
    logic                        prot1;
    logic                        prot2;
    logic                        use1;
    logic                        use2;
    logic [`MEM_DATA_W-1:0]      rdata1;
    logic [`MEM_DATA_W-1:0]      rdata2;
    logic [`MEM_DATA_W-1:0]      mem1_data;
    logic [`MEM_DATA_W-1:0]      mem2_data;
    logic [3:0][`MEM_DATA_W-1:0] ops;

    logic                        valid_q;
    logic [6:0]                  tag_q;
    opsel_e [3:0]                sel_q;
    logic [`MEM_DATA_W-1:0]      imm_q;
    logic [`MEM_DATA_W-1:0]      eip_q;
    logic [3:0][`MEM_DATA_W-1:0] regs_q;
    logic [`MEM_DATA_W-1:0]      phys1_q;
    logic [`MEM_DATA_W-1:0]      phys2_q;
    logic                        miss1_q;
    logic                        miss2_q;
    logic                        prot_q;

    rep_addr_gen u_rep (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .uop_i   (uop_i),
        .issue_o (issue),
        .addr1_o (addr1),
        .addr2_o (addr2),
        .stall_o (stall_o)
    );

    // upstream input is ignored during repeats, replay the captured copy
    always_ff @(posedge clk) begin
        if (!stall_o) begin
            hold_q      <= uop_i;
            regs_hold_q <= regs_i;
        end
    end

    assign cur_uop  = stall_o ? hold_q : uop_i;
    assign cur_regs = stall_o ? regs_hold_q : regs_i;

    // flags only count for addresses some operand reads
    always_comb begin
        use1 = 1'b0;
        use2 = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (cur_uop.sel[i] == OPSEL_MEM1) use1 = 1'b1;
            if (cur_uop.sel[i] == OPSEL_MEM2) use2 = 1'b1;
        end
    end

    dtlb u_tlb (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .tlb_wr_i (tlb_wr_i),
        .vaddr1_i (addr1),
        .vaddr2_i (addr2),
        .rw1_i    (cur_uop.rw1),
        .rw2_i    (cur_uop.rw2),
        .paddr1_o (paddr1),
        .paddr2_o (paddr2),
        .miss1_o  (miss1),
        .miss2_o  (miss2),
        .prot1_o  (prot1),
        .prot2_o  (prot2)
    );

    dcache_mem u_mem (
        .clk      (clk),
        .rd_en_i  (issue),
        .raddr1_i (paddr1),
        .raddr2_i (paddr2),
        .wb_i     (wb_i),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    // ******************************
    // issue pipeline register
    // ******************************

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            tag_q   <= cur_uop.tag;
            sel_q   <= cur_uop.sel;
            imm_q   <= cur_uop.imm;
            eip_q   <= cur_uop.eip;
            regs_q  <= cur_regs;
            phys1_q <= paddr1;
            phys2_q <= paddr2;
            miss1_q <= miss1 & use1;
            miss2_q <= miss2 & use2;
            prot_q  <= (prot1 & use1) | (prot2 & use2);
        end
    end

    // missed translation reads as zero
    assign mem1_data = miss1_q ? '0 : rdata1;
    assign mem2_data = miss2_q ? '0 : rdata2;

    operand_select u_ops (
        .sel_i  (sel_q),
        .regs_i (regs_q),
        .mem1_i (mem1_data),
        .mem2_i (mem2_data),
        .imm_i  (imm_q),
        .eip_i  (eip_q),
        .ops_o  (ops)
    );

    always_comb begin
        out_o.valid    = valid_q;
        out_o.tag      = tag_q;
        out_o.ops      = ops;
        out_o.phys1    = phys1_q;
        out_o.phys2    = phys2_q;
        out_o.tlb_miss = miss1_q | miss2_q;
        out_o.prot_exc = prot_q;
    end

endmodule

`default_nettype wire

/* tests/mem_stage_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_stage_defines.svh"

module mem_stage_tb
    import mem_stage_pkg::*;
();

    localparam int N       = `MEM_TLB_ENTRIES;
    localparam int PB      = `MEM_PAGE_BITS;
    localparam int AW      = $clog2(`MEM_WORDS);
    localparam int N_SEL   = 20;
    localparam int N_READ  = 24;
    localparam int N_FAULT = 24;
    localparam int N_REP   = 12;
    localparam int N_COLL  = 8;

    // reset, idle check, fill, three tlb loads, then the tests with margin
    localparam int CYCLE_LIMIT = 10 + 5 + `MEM_WORDS + 3 * N + 2 * N_SEL + 3 * N_READ
        + 2 * N_FAULT + 8 * N_REP + 3 * N_COLL + 100;

    typedef struct packed {
        mem_out_t out;
        logic     hit1;
        logic     hit2;
    } exp_t;

    logic                        clk = 1'b0;
    logic                        rst_n_i;
    mem_uop_t                    uop;
    logic [3:0][`MEM_DATA_W-1:0] regs;
    tlb_wr_t                     tlb_wr;
    wb_req_t                     wb;
    mem_out_t                    out;
    logic                        stall;

    logic [31:0] rng_state = 32'd23336;
    int          pass_cnt  = 0;
    int          fail_cnt  = 0;
    int          cycles    = 0;
    exp_t        exp_q[$];

    // reference state
    logic                                  m_present [N];
    logic                                  m_writable [N];
    logic [`MEM_DATA_W-PB-1:0]             m_vpn [N];
    logic [`MEM_DATA_W-PB-1:0]             m_pfn [N];
    logic [`MEM_DATA_W-1:0]                m_mem [`MEM_WORDS];

    mem_stage dut_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .uop_i    (uop),
        .regs_i   (regs),
        .tlb_wr_i (tlb_wr),
        .wb_i     (wb),
        .out_o    (out),
        .stall_o  (stall)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles, %0d outputs never arrived",
                     cycles, exp_q.size());
            $display("Testbench failed");
            $finish;
        end
    end

    // ******************************
    // helpers
    // ******************************

    function logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    // outputs are all registered, so the falling edge sees them settled
    task automatic tick();
        exp_t e;
        @(negedge clk);
        if (rst_n_i && out.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("output with tag %h arrived at %0t but none was expected",
                         out.tag, $time);
                fail_cnt++;
            end else begin
                e = exp_q.pop_front();
                check_val(32'(out.tag), 32'(e.out.tag), "tag");
                for (int i = 0; i < 4; i++) begin
                    check_val(out.ops[i], e.out.ops[i],
                              $sformatf("tag %h operand %0d", e.out.tag, i));
                end
                check_val(32'(out.tlb_miss), 32'(e.out.tlb_miss),
                          $sformatf("tag %h tlb_miss", e.out.tag));
                check_val(32'(out.prot_exc), 32'(e.out.prot_exc),
                          $sformatf("tag %h prot_exc", e.out.tag));
                if (e.hit1) begin
                    check_val(out.phys1, e.out.phys1, $sformatf("tag %h phys1", e.out.tag));
                end
                if (e.hit2) begin
                    check_val(out.phys2, e.out.phys2, $sformatf("tag %h phys2", e.out.tag));
                end
            end
        end
    endtask

    task automatic translate(input logic [31:0] va, output logic hit, output logic wr,
                             output logic [31:0] pa);
        hit = 1'b0;
        wr  = 1'b0;
        pa  = va;
        for (int i = 0; i < N; i++) begin
            if (m_present[i] && m_vpn[i] == va[31:PB]) begin
                hit = 1'b1;
                wr  = m_writable[i];
                pa  = {m_pfn[i], va[PB-1:0]};
            end
        end
    endtask

    // expected result of one issue at the given addresses
    task automatic predict(input logic [31:0] a1, input logic [31:0] a2);
        exp_t        e;
        logic        use1;
        logic        use2;
        logic        hit1;
        logic        hit2;
        logic        wr1;
        logic        wr2;
        logic [31:0] pa1;
        logic [31:0] pa2;
        logic [31:0] mem1;
        logic [31:0] mem2;
        use1 = 1'b0;
        use2 = 1'b0;
        for (int i = 0; i < 4; i++) begin
            use1 = use1 | (uop.sel[i] == OPSEL_MEM1);
            use2 = use2 | (uop.sel[i] == OPSEL_MEM2);
        end
        translate(a1, hit1, wr1, pa1);
        translate(a2, hit2, wr2, pa2);
        mem1 = (use1 && !hit1) ? 32'd0 : m_mem[pa1[AW+1:2]];
        mem2 = (use2 && !hit2) ? 32'd0 : m_mem[pa2[AW+1:2]];
        e = '0;
        e.out.valid = 1'b1;
        e.out.tag   = uop.tag;
        for (int i = 0; i < 4; i++) begin
            case (uop.sel[i])
                OPSEL_MEM1: e.out.ops[i] = mem1;
                OPSEL_MEM2: e.out.ops[i] = mem2;
                OPSEL_IMM:  e.out.ops[i] = uop.imm;
                OPSEL_EIP:  e.out.ops[i] = uop.eip;
                default:    e.out.ops[i] = regs[int'(uop.sel[i])];
            endcase
        end
        e.out.phys1    = pa1;
        e.out.phys2    = pa2;
        e.out.tlb_miss = (use1 && !hit1) || (use2 && !hit2);
        e.out.prot_exc = (use1 && hit1 && uop.rw1 && !wr1) || (use2 && hit2 && uop.rw2 && !wr2);
        e.hit1 = hit1;
        e.hit2 = hit2;
        exp_q.push_back(e);
    endtask

    function logic [31:0] random_addr(input logic mapped);
        logic [31:0] r;
        r = xorshift();
        if (mapped) begin
            return {m_vpn[r[31:30]], r[11:2], 2'b00};
        end
        return {r[31:2], 2'b00};
    endfunction

    task automatic random_uop(input logic use_mem, input logic mapped);
        logic [31:0] r;
        r = xorshift();
        uop           = '0;
        uop.df        = r[0];
        uop.rw1       = r[1];
        uop.rw2       = r[2];
        uop.tag       = r[9:3];
        uop.imm       = xorshift();
        uop.eip       = xorshift();
        uop.addr1     = random_addr(mapped);
        uop.addr2     = random_addr(mapped);
        for (int i = 0; i < 4; i++) begin
            r = xorshift();
            if (use_mem) begin
                uop.sel[i] = opsel_e'(r[2:0]);
            end else if (r % 6 < 4) begin
                uop.sel[i] = opsel_e'(r[1:0]);
            end else begin
                uop.sel[i] = (r % 6 == 4) ? OPSEL_IMM : OPSEL_EIP;
            end
            regs[i] = xorshift();
        end
        if (use_mem) begin
            uop.sel[0] = OPSEL_MEM1;
            uop.sel[3] = OPSEL_MEM2;
        end
    endtask

    // drive one uop, wait out its repeats and check the stall length
    task automatic send_uop();
        int          n_issue;
        int          stalls;
        logic [31:0] step;
        n_issue = uop.is_rep ? int'(uop.rep_count) : 1;
        step    = uop.df ? -32'd4 : 32'd4;
        for (int k = 0; k < n_issue; k++) begin
            predict(uop.addr1 + 32'(k) * step, uop.addr2 + 32'(k) * step);
        end
        uop.valid = 1'b1;
        tick();
        stalls = 0;
        while (stall) begin
            stalls++;
            tick();
        end
        uop.valid = 1'b0;
        check_val(32'(stalls), 32'(n_issue > 1 ? n_issue - 1 : 0),
                  $sformatf("tag %h stall cycles", uop.tag));
        // one output per issue edge, the last one right after the final issue
        check_val(32'(exp_q.size()), 32'd0,
                  $sformatf("tag %h outputs still pending", uop.tag));
    endtask

    task automatic write_word(input logic [31:0] pa, input logic [31:0] d);
        wb.valid     = 1'b1;
        wb.phys_addr = pa;
        wb.data      = d;
        tick();
        wb.valid     = 1'b0;
        m_mem[pa[AW+1:2]] = d;
    endtask

    // distinct vpn per entry, low bits hold the index
    task automatic program_tlb(input logic all_present, input logic all_writable);
        logic [31:0] r;
        logic [31:0] p;
        for (int i = 0; i < N; i++) begin
            r = xorshift();
            p = xorshift();
            tlb_wr.valid    = 1'b1;
            tlb_wr.index    = 2'(i);
            tlb_wr.vpn      = {r[19:2], 2'(i)};
            tlb_wr.pfn      = p[19:0];
            tlb_wr.present  = all_present | r[20];
            tlb_wr.writable = all_writable | r[21];
            m_present[i]    = tlb_wr.present;
            m_writable[i]   = tlb_wr.writable;
            m_vpn[i]        = tlb_wr.vpn;
            m_pfn[i]        = tlb_wr.pfn;
            tick();
        end
        tlb_wr.valid = 1'b0;
    endtask

    task automatic end_test(input string name, input int fails_before);
        while (exp_q.size() != 0) begin
            tick();
        end
        tick();
        $display("test %s done, %0d errors", name, fail_cnt - fails_before);
    endtask

    // ******************************
    // test sequence
    // ******************************

    initial begin
        logic [31:0] r;
        logic [31:0] pa;
        logic [1:0]  idx;
        logic        hit;
        logic        wr;
        int          f0;
        rst_n_i = 1'b0;
        uop     = '0;
        regs    = '0;
        tlb_wr  = '0;
        wb      = '0;
        for (int i = 0; i < N; i++) begin
            m_present[i] = 1'b0;
        end
        repeat (10) tick();
        rst_n_i = 1'b1;

        f0 = fail_cnt;
        repeat (5) begin
            tick();
            check_val(32'(out.valid), 32'd0, "valid after reset");
            check_val(32'(stall), 32'd0, "stall after reset");
        end
        end_test("reset_idle", f0);

        // every word gets a known value before any read
        for (int i = 0; i < `MEM_WORDS; i++) begin
            r = xorshift();
            write_word({r[31:AW+2], AW'(i), 2'b00}, xorshift());
        end

        f0 = fail_cnt;
        for (int n = 0; n < N_SEL; n++) begin
            random_uop(1'b0, 1'b0);
            send_uop();
        end
        end_test("reg_imm_eip_select", f0);

        f0 = fail_cnt;
        program_tlb(1'b1, 1'b1);
        for (int n = 0; n < N_READ; n++) begin
            r   = xorshift();
            idx = r[31:30];
            pa  = {m_pfn[idx], r[11:2], 2'b00};
            write_word(pa, xorshift());
            random_uop(1'b1, 1'b1);
            uop.addr1 = {m_vpn[idx], pa[11:0]};
            send_uop();
        end
        end_test("writeback_then_read", f0);

        f0 = fail_cnt;
        program_tlb(1'b0, 1'b0);
        for (int n = 0; n < N_FAULT; n++) begin
            r = xorshift();
            random_uop(1'b1, r[0]);
            send_uop();
        end
        end_test("miss_and_protection", f0);

        f0 = fail_cnt;
        program_tlb(1'b1, 1'b0);
        for (int n = 0; n < N_REP; n++) begin
            random_uop(1'b1, 1'b1);
            r = xorshift();
            uop.is_rep    = 1'b1;
            uop.rep_count = 16'(r % 7);
            send_uop();
        end
        end_test("rep_stepping", f0);

        // read and writeback to one word on the same edge
        f0 = fail_cnt;
        for (int n = 0; n < N_COLL; n++) begin
            random_uop(1'b1, 1'b1);
            translate(uop.addr1, hit, wr, pa);
            wb.valid     = 1'b1;
            wb.phys_addr = pa;
            wb.data      = xorshift();
            send_uop();
            wb.valid = 1'b0;
            m_mem[pa[AW+1:2]] = wb.data;
            send_uop();
        end
        end_test("same_edge_collision", f0);

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+hdl
hdl/mem_stage_pkg.sv
hdl/rep_addr_gen.sv
hdl/dtlb.sv
hdl/dcache_mem.sv
hdl/operand_select.sv
hdl/mem_stage.sv
tests/mem_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mem_stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/10ps -f files.f \
        --top-module mem_stage_tb -o mem_stage_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/mem_stage_sim)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
